/* rtl/ahb_buf_macros.svh */
`ifndef AHB_BUF_MACROS_SVH
`define AHB_BUF_MACROS_SVH

// Storage size in 32-bit words
// Any power of two works
`define AHB_BUF_MEM_WORDS 256

// Posted-write FIFO entries
// Power of two, at least 2
`define AHB_BUF_FIFO_DEPTH 4

// Word index width into storage
// Follows the storage depth
`define AHB_BUF_AW $clog2(`AHB_BUF_MEM_WORDS)

`endif

/* rtl/ahb_buf_pkg.sv */
package ahb_buf_pkg;

	// AHB-Lite HTRANS encodings
	typedef enum logic [1:0] {
		HTRANS_IDLE   = 2'b00,
		HTRANS_BUSY   = 2'b01,
		HTRANS_NONSEQ = 2'b10,
		HTRANS_SEQ    = 2'b11
	} htrans_e;

	// AHB-Lite HSIZE encodings up to a word
	// Larger codes may still appear on the bus and are flagged as errors
	typedef enum logic [2:0] {
		HSIZE_BYTE = 3'b000,
		HSIZE_HALF = 3'b001,
		HSIZE_WORD = 3'b010
	} hsize_e;

	// One posted write, 68 bits
	typedef struct packed {
		logic [29:0] addr;    // Word address, haddr[31:2]
		logic [3:0]  strb;    // Byte lane enables
		logic [31:0] data;    // Write data as seen on hwdata
		logic [1:0]  pad;     // Always zero
	} buf_req_t;

	// Bus-side FSM states
	typedef enum logic [2:0] {
		ST_IDLE,         // No data phase in progress
		ST_WRITE,        // Write data phase, waits on a full FIFO
		ST_READ_WAIT,    // Read held until the FIFO drains
		ST_READ_DATA,    // Read data on hrdata
		ST_ERR1,         // First ERROR cycle, hready low
		ST_ERR2          // Second ERROR cycle, hready high
	} swc_state_e;

endpackage

/* rtl/ahbs_swc.sv */
`timescale 1ns/100ps
`include "ahb_buf_macros.svh"

module ahbs_swc import ahb_buf_pkg::*; (
	input  logic                   hclk,
	input  logic                   hrstn,
	input  logic [31:0]            haddr,
	input  htrans_e                htrans,
	input  logic                   hwrite,
	input  hsize_e                 hsize,
	// Protection and lock are not used by this slave
	input  logic [6:0]             hprot,
	input  logic                   hmastlock,
	input  logic [31:0]            hwdata,
	output logic [31:0]            hrdata,
	output logic                   hready,
	output logic                   hresp,
	// FIFO side
	input  logic                   full,
	input  logic                   empty,
	output logic                   wreq,
	output buf_req_t               wbuf,
	// Storage read side
	output logic                   rreq,
	output logic [`AHB_BUF_AW-1:0] rbuffaddr,
	input  logic [31:0]            rbuffdata
);

	swc_state_e state;
	swc_state_e state_d;
	swc_state_e addr_next;

	logic        addr_valid;
	logic        addr_err;
	logic [31:0] addr_q;
	hsize_e      size_q;
	logic [3:0]  strb;

	// SEQ counts as NONSEQ, BUSY as IDLE
	assign addr_valid = (htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ);

	// Too wide, or not aligned to its own size
	assign addr_err = (hsize > HSIZE_WORD) ||
		((hsize == HSIZE_HALF) && haddr[0]) ||
		((hsize == HSIZE_WORD) && (haddr[1:0] != 2'b00));

	// State entered from a new address phase
	always_comb begin
		if (!addr_valid)
			addr_next = ST_IDLE;
		else if (addr_err)
			addr_next = ST_ERR1;
		else if (hwrite)
			addr_next = ST_WRITE;
		else
			addr_next = ST_READ_WAIT;
	end

	always_comb begin
		state_d = state;
		case (state)
			ST_WRITE:     if (!full) state_d = addr_next;
			ST_READ_WAIT: if (empty) state_d = ST_READ_DATA;
			ST_ERR1:      state_d = ST_ERR2;
			// Idle, read data and second error cycle all sample a new address
			default:      state_d = addr_next;
		endcase
	end

	always_ff @(posedge hclk or negedge hrstn) begin
		if (!hrstn)
			state <= ST_IDLE;
		else
			state <= state_d;
	end

	// Address phase capture
	always_ff @(posedge hclk) begin
		if (hready && addr_valid) begin
			addr_q <= haddr;
			size_q <= hsize;
		end
	end

	// Byte lanes from the captured size and offset
	always_comb begin
		case (size_q)
			HSIZE_BYTE: strb = 4'b0001 << addr_q[1:0];
			HSIZE_HALF: strb = addr_q[1] ? 4'b1100 : 4'b0011;
			default:    strb = 4'b1111;
		endcase
	end

	// Bus response
	always_comb begin
		case (state)
			ST_WRITE:              hready = !full;
			ST_READ_WAIT, ST_ERR1: hready = 1'b0;
			default:               hready = 1'b1;
		endcase
	end
	assign hresp  = (state == ST_ERR1) || (state == ST_ERR2);
	assign hrdata = (state == ST_READ_DATA) ? rbuffdata : 32'h0;

	// Push in the write data phase with data straight off hwdata
	assign wreq      = (state == ST_WRITE) && !full;
	assign wbuf.addr = addr_q[31:2];
	assign wbuf.strb = strb;
	assign wbuf.data = hwdata;
	assign wbuf.pad  = 2'b00;

	// Single read strobe once earlier writes are in storage
	assign rreq      = (state == ST_READ_WAIT) && empty;
	assign rbuffaddr = addr_q[`AHB_BUF_AW+1:2];

	// A push always leaves the FIFO non-empty in the next cycle
	a_push_lands: assert property (@(posedge hclk) disable iff (!hrstn)
		wreq |=> !empty);

	// No read strobe in the cycle right after a push
	a_rreq_after_drain: assert property (@(posedge hclk) disable iff (!hrstn)
		rreq |-> !$past(wreq));

endmodule

/* rtl/req_fifo.sv */
`timescale 1ns/100ps
`include "ahb_buf_macros.svh"

module req_fifo import ahb_buf_pkg::*; (
	input  logic     hclk,
	input  logic     hrstn,
	// Push side, never pushed while full
	input  logic     wreq,
	input  buf_req_t wbuf,
	output logic     full,
	output logic     empty,
	// Drain side
	output logic     drain_valid,
	output buf_req_t drain_req,
	input  logic     drain_ready
);

	localparam int PW = $clog2(`AHB_BUF_FIFO_DEPTH);
	localparam logic [PW:0] DEPTH = (PW+1)'(`AHB_BUF_FIFO_DEPTH);

	buf_req_t mem [`AHB_BUF_FIFO_DEPTH];

	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [PW:0]   count;
	logic          pop;

	assign pop = drain_valid && drain_ready;

	// Entry storage
	always_ff @(posedge hclk) begin
		if (wreq)
			mem[wr_ptr] <= wbuf;
	end

	// Pointers wrap on their own with a power-of-two depth
	always_ff @(posedge hclk or negedge hrstn) begin
		if (!hrstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wreq)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Occupancy
	always_ff @(posedge hclk or negedge hrstn) begin
		if (!hrstn)
			count <= '0;
		else begin
			case ({wreq, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign full        = (count == DEPTH);
	assign empty       = (count == '0);
	assign drain_valid = !empty;
	// Head entry, held while the drain stalls
	assign drain_req   = mem[rd_ptr];

	a_count_max: assert property (@(posedge hclk) disable iff (!hrstn)
		count <= DEPTH);

endmodule

/* rtl/buf_mem.sv */
`timescale 1ns/100ps
`include "ahb_buf_macros.svh"

module buf_mem import ahb_buf_pkg::*; (
	input  logic                   hclk,
	input  logic                   hrstn,
	// Drain from the FIFO
	input  logic                   drain_valid,
	input  buf_req_t               drain_req,
	output logic                   drain_ready,
	// Read port, one cycle latency
	input  logic                   rreq,
	input  logic [`AHB_BUF_AW-1:0] rbuffaddr,
	output logic [31:0]            rbuffdata
);

	logic [31:0] mem [`AHB_BUF_MEM_WORDS];

	logic                   drain_fire;
	logic [`AHB_BUF_AW-1:0] drain_idx;

	// Read wins the cycle, draining resumes after
	assign drain_ready = !rreq;
	assign drain_fire  = drain_valid && drain_ready;
	// Low address bits select the word, upper bits alias
	assign drain_idx   = drain_req.addr[`AHB_BUF_AW-1:0];

	// Lane-wise merge of a drained write
	always_ff @(posedge hclk) begin
		if (drain_fire) begin
			for (int i = 0; i < 4; i++) begin
				if (drain_req.strb[i])
					mem[drain_idx][8*i +: 8] <= drain_req.data[8*i +: 8];
			end
		end
	end

	// Registered read
	always_ff @(posedge hclk) begin
		if (rreq)
			rbuffdata <= mem[rbuffaddr];
	end

	// Reads come only after the FIFO is empty, so no drain is ever pending
	a_read_no_drain: assert property (@(posedge hclk) disable iff (!hrstn)
		rreq |-> !drain_valid);

endmodule

/* rtl/ahb_buf_top.sv */
`timescale 1ns/100ps
`include "ahb_buf_macros.svh"

module ahb_buf_top import ahb_buf_pkg::*; (
	input  logic        hclk,
	input  logic        hrstn,
	input  logic [31:0] haddr,
	input  logic [1:0]  htrans,
	input  logic        hwrite,
	input  logic [2:0]  hsize,
	input  logic [6:0]  hprot,
	input  logic        hmastlock,
	input  logic [31:0] hwdata,
	output logic [31:0] hrdata,
	output logic        hready,
	output logic        hresp
);

	// Slave to FIFO
	logic     wreq;
	buf_req_t wbuf;
	logic     full;
	logic     empty;

	// FIFO to storage
	logic     drain_valid;
	buf_req_t drain_req;
	logic     drain_ready;

	// Slave to storage
	logic                   rreq;
	logic [`AHB_BUF_AW-1:0] rbuffaddr;
	logic [31:0]            rbuffdata;

	// Raw bus codes cast onto the package encodings
	ahbs_swc u_swc (
		.hclk(hclk), .hrstn(hrstn),
		.haddr(haddr), .htrans(htrans_e'(htrans)), .hwrite(hwrite),
		.hsize(hsize_e'(hsize)), .hprot(hprot), .hmastlock(hmastlock),
		.hwdata(hwdata), .hrdata(hrdata), .hready(hready), .hresp(hresp),
		.full(full), .empty(empty), .wreq(wreq), .wbuf(wbuf),
		.rreq(rreq), .rbuffaddr(rbuffaddr), .rbuffdata(rbuffdata)
	);

	req_fifo u_fifo (
		.hclk(hclk), .hrstn(hrstn),
		.wreq(wreq), .wbuf(wbuf), .full(full), .empty(empty),
		.drain_valid(drain_valid), .drain_req(drain_req), .drain_ready(drain_ready)
	);

	buf_mem u_mem (
		.hclk(hclk), .hrstn(hrstn),
		.drain_valid(drain_valid), .drain_req(drain_req), .drain_ready(drain_ready),
		.rreq(rreq), .rbuffaddr(rbuffaddr), .rbuffdata(rbuffdata)
	);

endmodule

/* verif/tb_clkgen.sv */
`timescale 1ns/100ps

module tb_clkgen (
	output logic hclk,
	output logic hrstn
);

	localparam int HALF_NS = 5;

	// 10 ns free-running clock
	initial begin
		hclk = 1'b0;
		forever #HALF_NS hclk = ~hclk;
	end

	// Reset held over the first two rising edges
	initial begin
		hrstn = 1'b0;
		repeat (2) @(posedge hclk);
		hrstn <= 1'b1;
	end

endmodule

/* verif/tb_checker.sv */
`timescale 1ns/100ps
`include "ahb_buf_macros.svh"

module tb_checker import ahb_buf_pkg::*; (
	input  logic        hclk,
	input  logic        hrstn,
	input  logic [31:0] haddr,
	input  logic [1:0]  htrans,
	input  logic        hwrite,
	input  logic [2:0]  hsize,
	input  logic [31:0] hwdata,
	input  logic [31:0] hrdata,
	input  logic        hready,
	input  logic        hresp,
	input  logic        test_end,
	input  int          test_num,
	input  logic        need_stall,
	output int          err_total,
	output int          check_total
);

	// Expected storage contents of written bytes
	logic [31:0] shadow [`AHB_BUF_MEM_WORDS];

	// Data phase in flight
	logic        pend_valid;
	logic        pend_write;
	logic        pend_bad;
	logic [31:0] pend_addr;
	logic [2:0]  pend_size;
	int          pend_waits;

	int test_errs;
	int test_checks;
	int stall_cycles;

	// Wider than a word, or not on its own size boundary
	function automatic logic bad_xfer(input logic [2:0] size, input logic [31:0] addr);
		if (size > 3'd2)
			return 1'b1;
		if (size == 3'd1)
			return addr[0];
		if (size == 3'd2)
			return addr[1:0] != 2'b00;
		return 1'b0;
	endfunction

	// Lanes a legal transfer touches from its byte count upward
	function automatic logic [3:0] lane_mask(input logic [2:0] size, input logic [1:0] off);
		int         nbytes;
		logic [3:0] mask;
		nbytes = 1 << size;
		mask   = 4'b0000;
		for (int i = 0; i < 4; i++)
			mask[i] = (i >= int'(off)) && (i < int'(off) + nbytes);
		return mask;
	endfunction

	// Reference read value for a byte address
	function automatic logic [31:0] expected_rdata(input logic [31:0] addr);
		return shadow[addr[`AHB_BUF_AW+1:2]];
	endfunction

	task automatic compare(input string sig, input logic [31:0] exp, input logic [31:0] act);
		test_checks++;
		if (exp !== act) begin
			$display("ERR %0t ns %s expected %h actual %h", $time, sig, exp, act);
			test_errs++;
		end
	endtask

	task automatic fail_plain(input string what);
		test_errs++;
		$display("Failure at %0t ns: %s", $time, what);
	endtask

	task automatic merge_write(input logic [31:0] addr, input logic [2:0] size,
		input logic [31:0] data);
		logic [3:0] mask;
		mask = lane_mask(size, addr[1:0]);
		for (int i = 0; i < 4; i++) begin
			if (mask[i])
				shadow[addr[`AHB_BUF_AW+1:2]][8*i +: 8] = data[8*i +: 8];
		end
	endtask

	initial begin
		pend_valid   = 1'b0;
		pend_waits   = 0;
		test_errs    = 0;
		test_checks  = 0;
		stall_cycles = 0;
		err_total    = 0;
		check_total  = 0;
		for (int i = 0; i < `AHB_BUF_MEM_WORDS; i++)
			shadow[i] = 32'h0;
	end

	always @(posedge hclk) begin
		if (!hrstn) begin
			pend_valid = 1'b0;
		end else begin
			if (!hready)
				stall_cycles++;
			// hresp follows the error rule in every data phase cycle
			if (pend_valid) begin
				compare("hresp", {31'b0, pend_bad}, {31'b0, hresp});
				if (!hready)
					pend_waits++;
				else if (pend_bad && pend_waits == 0)
					fail_plain("ERROR response had no first cycle with hready low");
				else if (!pend_bad && pend_write)
					merge_write(pend_addr, pend_size, hwdata);
				else if (!pend_bad)
					compare("hrdata", expected_rdata(pend_addr), hrdata);
			end else begin
				compare("hresp", 32'h0, {31'b0, hresp});
			end
			// New address phase where BUSY counts as IDLE
			if (hready) begin
				pend_valid = (htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ);
				pend_write = hwrite;
				pend_addr  = haddr;
				pend_size  = hsize;
				pend_bad   = bad_xfer(hsize, haddr);
				pend_waits = 0;
			end
			if (test_end) begin
				if (need_stall && stall_cycles == 0)
					fail_plain("hready never went low during this test");
				$display("Test %0d finished: %0d checks, %0d errors",
					test_num, test_checks, test_errs);
				err_total    += test_errs;
				check_total  += test_checks;
				test_errs    = 0;
				test_checks  = 0;
				stall_cycles = 0;
			end
		end
	end

endmodule

/* verif/tb_top.sv */
`timescale 1ns/100ps
`include "ahb_buf_macros.svh"

module tb_top import ahb_buf_pkg::*; ();

	localparam logic [31:0] SEED = 32'h6917;
	localparam int RAND_XFERS = 200;
	localparam int WIN_WORDS  = 16;
	localparam logic [31:0] WIN_BASE = 32'h200;
	// Tests 1 to 5, then the preload and random part of test 6
	localparam int TOTAL_XFERS = 2 + 8 + 16 + 3 + 6 + WIN_WORDS + RAND_XFERS;
	localparam int CYCLES_PER_XFER = 20;
	localparam int CLK_NS = 10;

	logic        hclk;
	logic        hrstn;
	logic [31:0] haddr;
	logic [1:0]  htrans;
	logic        hwrite;
	logic [2:0]  hsize;
	logic [6:0]  hprot;
	logic        hmastlock;
	logic [31:0] hwdata;
	logic [31:0] hrdata;
	logic        hready;
	logic        hresp;

	logic        test_end;
	int          test_num;
	logic        need_stall;
	int          err_total;
	int          check_total;
	logic [31:0] rng;

	tb_clkgen u_clk (.hclk(hclk), .hrstn(hrstn));

	ahb_buf_top DUT (
		.hclk(hclk), .hrstn(hrstn),
		.haddr(haddr), .htrans(htrans), .hwrite(hwrite), .hsize(hsize),
		.hprot(hprot), .hmastlock(hmastlock), .hwdata(hwdata),
		.hrdata(hrdata), .hready(hready), .hresp(hresp)
	);

	tb_checker u_chk (
		.hclk(hclk), .hrstn(hrstn),
		.haddr(haddr), .htrans(htrans), .hwrite(hwrite), .hsize(hsize),
		.hwdata(hwdata), .hrdata(hrdata), .hready(hready), .hresp(hresp),
		.test_end(test_end), .test_num(test_num), .need_stall(need_stall),
		.err_total(err_total), .check_total(check_total)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Address phase, returns at the edge that accepts it
	task automatic bus_xfer(input logic wr, input logic [31:0] addr, input logic [2:0] size,
		input logic [31:0] data);
		haddr  <= addr;
		htrans <= HTRANS_NONSEQ;
		hwrite <= wr;
		hsize  <= size;
		@(posedge hclk);
		while (!hready)
			@(posedge hclk);
		// Write data held through the following data phase
		if (wr)
			hwdata <= data;
	endtask

	// Idle address phase until the last data phase ends
	task automatic bus_idle();
		htrans <= HTRANS_IDLE;
		hwrite <= 1'b0;
		@(posedge hclk);
		while (!hready)
			@(posedge hclk);
	endtask

	task automatic end_test(input int num);
		bus_idle();
		test_num <= num;
		test_end <= 1'b1;
		@(posedge hclk);
		test_end   <= 1'b0;
		need_stall <= 1'b0;
	endtask

	initial begin
		#(TOTAL_XFERS * CYCLES_PER_XFER * CLK_NS);
		$display("Timeout: transfers still running after %0d ns",
			TOTAL_XFERS * CYCLES_PER_XFER * CLK_NS);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [31:0] addr;
		haddr      = 32'h0;
		htrans     = HTRANS_IDLE;
		hwrite     = 1'b0;
		hsize      = HSIZE_WORD;
		hprot      = 7'h03;
		hmastlock  = 1'b0;
		hwdata     = 32'h0;
		test_end   = 1'b0;
		test_num   = 0;
		need_stall = 1'b0;
		rng        = SEED;
		@(posedge hrstn);
		@(posedge hclk);

		// Word write and readback
		rng = lcg_next(rng);
		bus_xfer(1'b1, 32'h40, HSIZE_WORD, rng);
		bus_xfer(1'b0, 32'h40, HSIZE_WORD, 32'h0);
		end_test(1);

		// Bytes at every offset, then both halves, into one word
		bus_xfer(1'b1, 32'h80, HSIZE_WORD, 32'h11223344);
		for (int i = 0; i < 4; i++) begin
			rng = lcg_next(rng);
			bus_xfer(1'b1, 32'h80 + i, HSIZE_BYTE, rng);
		end
		rng = lcg_next(rng);
		bus_xfer(1'b1, 32'h80, HSIZE_HALF, rng);
		rng = lcg_next(rng);
		bus_xfer(1'b1, 32'h82, HSIZE_HALF, rng);
		bus_xfer(1'b0, 32'h80, HSIZE_WORD, 32'h0);
		end_test(2);

		// Burst of eight writes past the FIFO depth, then readback
		need_stall <= 1'b1;
		for (int i = 0; i < 8; i++) begin
			rng = lcg_next(rng);
			bus_xfer(1'b1, 32'hC0 + 4 * i, HSIZE_WORD, rng);
		end
		for (int i = 0; i < 8; i++)
			bus_xfer(1'b0, 32'hC0 + 4 * i, HSIZE_WORD, 32'h0);
		end_test(3);

		// Read straight after two writes to the same word
		bus_xfer(1'b1, 32'h100, HSIZE_WORD, 32'hAAAA5555);
		bus_xfer(1'b1, 32'h100, HSIZE_WORD, 32'h0F0F1234);
		bus_xfer(1'b0, 32'h100, HSIZE_WORD, 32'h0);
		end_test(4);

		// Misaligned and oversized transfers leave the word alone
		bus_xfer(1'b1, 32'h140, HSIZE_WORD, 32'hC0FFEE11);
		bus_xfer(1'b1, 32'h141, HSIZE_HALF, 32'hFFFFFFFF);
		bus_xfer(1'b1, 32'h142, HSIZE_WORD, 32'hFFFFFFFF);
		bus_xfer(1'b1, 32'h140, 3'b011, 32'hFFFFFFFF);
		bus_xfer(1'b0, 32'h143, HSIZE_HALF, 32'h0);
		bus_xfer(1'b0, 32'h140, HSIZE_WORD, 32'h0);
		end_test(5);

		// Known contents for the random window
		for (int i = 0; i < WIN_WORDS; i++) begin
			rng = lcg_next(rng);
			bus_xfer(1'b1, WIN_BASE + 4 * i, HSIZE_WORD, rng);
		end
		// Upper LCG bits pick direction, size, word and offset
		for (int n = 0; n < RAND_XFERS; n++) begin
			rng  = lcg_next(rng);
			r    = rng;
			rng  = lcg_next(rng);
			addr = WIN_BASE + {26'b0, r[19:16], 2'b00} + {30'b0, r[21:20]};
			bus_xfer(r[24], addr, {1'b0, r[27:26]}, rng);
		end
		end_test(6);

		@(posedge hclk);
		$display("All tests finished: %0d checks, %0d errors", check_total, err_total);
		if (err_total == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* ahb_buf_top.f */
+incdir+rtl
rtl/ahb_buf_pkg.sv
rtl/ahbs_swc.sv
rtl/req_fifo.sv
rtl/buf_mem.sv
rtl/ahb_buf_top.sv
verif/tb_clkgen.sv
verif/tb_checker.sv
verif/tb_top.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
	-f ahb_buf_top.f -o tb_top_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/tb_top_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Done: errors found" sim.log; then
	exit 1
fi
exit 0
